//--- tb.f
+incdir+design
design/renderPkg.sv
design/streamIf.sv
design/streamFifo.sv
design/configRegisterFile.sv
design/framebufferControl.sv
design/commandParser.sv
design/renderFrontEnd.sv
tests/renderFrontEndTb.sv

//--- Makefile
# Verilator simulation of the render front end testbench

TOP = renderFrontEndTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fail unless it reports success"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f tb.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- tests/renderFrontEndTb.sv
/* Testbench for the render front end. Streams a table of commands into the DUT
   and checks triangle, texel, config and framebuffer outputs against models. */
`timescale 1ns/1ps

module renderFrontEndTb;
    import renderPkg::*;

    localparam int numTests = 14;
    localparam int holdCycles = 60;

    typedef struct packed
    {
        logic [3:0]  op;
        logic [27:0] arg;
        cmdWordT     value;
        logic        hold;
    } testEntryT;

    // Opcode, header argument, payload base or config value, long triTready stall
    testEntryT tests [numTests] = '{
        '{opTriangleStream, 28'd3, 32'h1000_0a01, 1'b0},
        '{opTextureStream, 28'd2, 32'h2000_7b10, 1'b0},
        '{opRenderConfig, 28'd3, 32'h1122_3344, 1'b0},
        '{opRenderConfig, 28'd4, 32'habcd_5678, 1'b0},
        '{opFramebuffer, 28'hd, 32'h0, 1'b0},
        '{opTriangleStream, 28'd2, 32'h3000_0c20, 1'b0},
        '{opNop, 28'h123, 32'h0, 1'b0},
        '{4'hf, 28'h55, 32'h0, 1'b0},
        '{opTriangleStream, 28'd6, 32'h4000_0d30, 1'b1},
        '{opRenderConfig, 28'd1, 32'h0040_0080, 1'b0},
        '{opTextureStream, 28'd3, 32'h5000_e840, 1'b0},
        '{opFramebuffer, 28'h6, 32'h0, 1'b0},
        '{opTriangleStream, 28'd0, 32'h0, 1'b0},
        '{opRenderConfig, 28'd0, 32'h0000_00ff, 1'b0}
    };

    logic        aclk;
    logic        resetn;
    logic        cmdTvalid;
    logic        cmdTready;
    logic        cmdTlast;
    cmdWordT     cmdTdata;
    logic        triTvalid;
    logic        triTready;
    logic        triTlast;
    cmdWordT     triTdata;
    logic        texTvalid;
    logic        texTready;
    logic        texTlast;
    texelT       texTdata;
    logic        rasterizerRunning;
    logic        pixelInPipeline;
    logic        startRendering;
    cmdWordT     confFeatureEnable;
    cmdWordT     confScissorStartXY;
    cmdWordT     confScissorEndXY;
    cmdWordT     confColorClear;
    logic [15:0] confDepthClear;
    logic        colorBufferApply;
    logic        depthBufferApply;
    logic        bufferCommit;
    logic        bufferMemset;
    logic        colorBufferApplied;
    logic        depthBufferApplied;

    cmdWordT   cmdQ [$];
    logic      lastQ [$];
    cmdWordT   triQ [$];
    logic      triLastQ [$];
    texelT     texQ [$];
    logic      texLastQ [$];
    fbRequestT fbSeenQ [$];

    int errorCount = 0;
    int failedTests = 0;
    int startCount = 0;
    int ackCount = 0;
    int triCount = 0;
    int sent = 0;
    int holdAt = -1;
    int cycleLimit = 1000;

    renderFrontEnd dut0 (.*);

    function automatic cmdWordT payloadWord(int t, int k);
        return tests[t].value + cmdWordT'(k) * 32'h0101_0001;
    endfunction

    function automatic int payloadCount(int t);
        case (tests[t].op)
            opTriangleStream: return int'(tests[t].arg[15:0]);
            opTextureStream:  return (tests[t].arg[4:0] == 5'd0) ? 0 : 1 << tests[t].arg[4:0];
            opRenderConfig:   return 1;
            default:          return 0;
        endcase
    endfunction

    function automatic string opName(logic [3:0] op);
        case (op)
            opTriangleStream: return "triangle";
            opTextureStream:  return "texture";
            opRenderConfig:   return "config";
            opFramebuffer:    return "framebuffer";
            opNop:            return "nop";
            default:          return "unknown opcode";
        endcase
    endfunction

    function automatic cmdWordT readConfig(configIndexT i);
        case (i)
            3'd0:    return confFeatureEnable;
            3'd1:    return confScissorStartXY;
            3'd2:    return confScissorEndXY;
            3'd3:    return confColorClear;
            3'd4:    return {16'h0, confDepthClear};
            default: return '0;
        endcase
    endfunction

    // Depth clear only shows the low half of its register
    function automatic cmdWordT configView(configIndexT i, cmdWordT v);
        return (i == 3'd4) ? {16'h0, v[15:0]} : v;
    endfunction

    task automatic expectWord(string name, cmdWordT got, cmdWordT exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareTexel(string name, texelT got, texelT exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial
    begin
        do
        begin
            @(posedge aclk);
            cycleLimit--;
        end
        while (cycleLimit > 0);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("ERRORS FOUND");
        $finish;
    end

    // Host side command driver
    initial
    begin
        cmdTvalid = 1'b0;
        cmdTlast = 1'b0;
        cmdTdata = '0;
        wait (resetn === 1'b1);
        @(posedge aclk);
        while (sent < cmdQ.size())
        begin
            cmdTvalid <= 1'b1;
            cmdTdata <= cmdQ[sent];
            cmdTlast <= lastQ[sent];
            @(posedge aclk);
            if (cmdTready)
                sent++;
        end
        cmdTvalid <= 1'b0;
    end

    // Rasterizer model with one long stall before the marked triangle stream
    initial
    begin
        int   holdLeft;
        logic holdDone;
        holdLeft = 0;
        holdDone = 1'b0;
        triTready = 1'b0;
        wait (resetn === 1'b1);
        forever
        begin
            @(posedge aclk);
            if (triTvalid && triTready)
            begin
                triQ.push_back(triTdata);
                triLastQ.push_back(triTlast);
                triCount++;
                if (colorBufferApply || depthBufferApply)
                begin
                    $display("Triangle word sent at %0t while a buffer apply was pending", $time);
                    errorCount++;
                end
            end
            if (holdLeft > 0)
            begin
                holdLeft--;
                triTready <= 1'b0;
            end
            else if (!holdDone && triCount == holdAt)
            begin
                holdDone = 1'b1;
                holdLeft = holdCycles;
                triTready <= 1'b0;
            end
            else
                triTready <= ($urandom % 4) != 0;
        end
    end

    initial
    begin
        texTready = 1'b0;
        wait (resetn === 1'b1);
        forever
        begin
            @(posedge aclk);
            if (texTvalid && texTready)
            begin
                texQ.push_back(texTdata);
                texLastQ.push_back(texTlast);
            end
            texTready <= ($urandom % 3) != 0;
        end
    end

    initial
    begin
        rasterizerRunning = 1'b0;
        pixelInPipeline = 1'b0;
        wait (resetn === 1'b1);
        forever
        begin
            @(posedge aclk);
            if (startRendering)
            begin
                startCount++;
                repeat (1 + $urandom % 3) @(posedge aclk);
                rasterizerRunning <= 1'b1;
                repeat (4 + $urandom % 4) @(posedge aclk);
                rasterizerRunning <= 1'b0;
                pixelInPipeline <= 1'b1;
                repeat (2) @(posedge aclk);
                pixelInPipeline <= 1'b0;
            end
        end
    end

    // Buffers drop applied while working, then raise it again
    initial
    begin
        colorBufferApplied = 1'b1;
        depthBufferApplied = 1'b1;
        wait (resetn === 1'b1);
        forever
        begin
            @(posedge aclk);
            if (colorBufferApply || depthBufferApply)
            begin
                fbSeenQ.push_back({bufferCommit, bufferMemset, colorBufferApply, depthBufferApply});
                repeat (2 + $urandom % 3) @(posedge aclk);
                colorBufferApplied <= 1'b0;
                depthBufferApplied <= 1'b0;
                repeat (3 + $urandom % 4) @(posedge aclk);
                colorBufferApplied <= 1'b1;
                depthBufferApplied <= 1'b1;
                while (colorBufferApply || depthBufferApply)
                    @(posedge aclk);
                ackCount++;
            end
        end
    end

    initial
    begin
        int          t;
        int          k;
        int          n;
        int          triTotal;
        int          errorsBefore;
        int          expectedStarts;
        int          expectedAcks;
        int          waited;
        cmdWordT     got;
        logic        gotLast;
        texelT       gotTexel;
        fbRequestT   seen;
        configIndexT idx;
        cmdWordT     shadow [8];

        void'($urandom(32'h42b0));
        resetn = 1'b0;
        triTotal = 0;
        expectedStarts = 0;
        expectedAcks = 0;
        for (t = 0; t < 8; t++)
            shadow[t] = '0;

        for (t = 0; t < numTests; t++)
        begin
            n = payloadCount(t);
            cmdQ.push_back({tests[t].op, tests[t].arg});
            lastQ.push_back(n == 0);
            for (k = 0; k < n; k++)
            begin
                cmdQ.push_back(payloadWord(t, k));
                lastQ.push_back(k == n - 1);
            end
            if (tests[t].hold && holdAt < 0)
                holdAt = triTotal;
            if (tests[t].op == opTriangleStream)
                triTotal += n;
        end
        cycleLimit = cmdQ.size() * 20 + 200;

        repeat (8) @(posedge aclk);
        resetn <= 1'b1;

        for (t = 0; t < numTests; t++)
        begin
            errorsBefore = errorCount;
            n = payloadCount(t);
            case (tests[t].op)
                opTriangleStream:
                begin
                    for (k = 0; k < n; k++)
                    begin
                        while (triQ.size() == 0)
                            @(posedge aclk);
                        got = triQ.pop_front();
                        gotLast = triLastQ.pop_front();
                        expectWord("triTdata", got, payloadWord(t, k));
                        checkFlag("triTlast", gotLast, k == n - 1);
                    end
                    if (n > 0)
                        expectedStarts++;
                    while (startCount < expectedStarts)
                        @(posedge aclk);
                end
                opTextureStream:
                begin
                    for (k = 0; k < n; k++)
                    begin
                        while (texQ.size() == 0)
                            @(posedge aclk);
                        gotTexel = texQ.pop_front();
                        gotLast = texLastQ.pop_front();
                        compareTexel("texTdata", gotTexel, texelT'(payloadWord(t, k)));
                        checkFlag("texTlast", gotLast, k == n - 1);
                    end
                end
                opRenderConfig:
                begin
                    idx = tests[t].arg[2:0];
                    shadow[idx] = tests[t].value;
                    waited = 0;
                    while (readConfig(idx) !== configView(idx, shadow[idx]) && waited < 200)
                    begin
                        @(posedge aclk);
                        waited++;
                    end
                    if (waited == 200)
                    begin
                        $display("Config register %0d never took its new value", idx);
                        errorCount++;
                    end
                    expectWord("confFeatureEnable", confFeatureEnable, shadow[0]);
                    expectWord("confScissorStartXY", confScissorStartXY, shadow[1]);
                    expectWord("confScissorEndXY", confScissorEndXY, shadow[2]);
                    expectWord("confColorClear", confColorClear, shadow[3]);
                    expectWord("confDepthClear", {16'h0, confDepthClear},
                        {16'h0, shadow[4][15:0]});
                end
                opFramebuffer:
                begin
                    while (fbSeenQ.size() == 0)
                        @(posedge aclk);
                    seen = fbSeenQ.pop_front();
                    checkFlag("bufferCommit", seen.commit, tests[t].arg[0]);
                    checkFlag("bufferMemset", seen.memset, tests[t].arg[1]);
                    checkFlag("colorBufferApply", seen.colorSelect, tests[t].arg[2]);
                    checkFlag("depthBufferApply", seen.depthSelect, tests[t].arg[3]);
                    expectedAcks++;
                    while (ackCount < expectedAcks)
                        @(posedge aclk);
                end
                default:
                    ;
            endcase
            if (errorCount == errorsBefore)
                $display("Test %0d %s: passed", t, opName(tests[t].op));
            else
            begin
                failedTests++;
                $display("Test %0d %s: failed with %0d errors", t, opName(tests[t].op),
                    errorCount - errorsBefore);
            end
        end

        // Nothing may trail the last command
        repeat (50) @(posedge aclk);
        if (triQ.size() != 0 || texQ.size() != 0 || fbSeenQ.size() != 0)
        begin
            $display("Outputs appeared that no command asked for");
            errorCount++;
        end
        if (startCount != expectedStarts)
        begin
            $display("startRendering rose %0d times instead of %0d", startCount, expectedStarts);
            errorCount++;
        end

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", numTests, failedTests,
            errorCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- design/renderFrontEnd.sv
/* Top level of the render command front end. Connects the command and
   texture FIFOs, the parser, the config registers and the buffer control. */
`timescale 1ns/1ps
`include "render_params.svh"

module renderFrontEnd
(
    input  logic               aclk,
    input  logic               resetn,
    input  logic               cmdTvalid,
    output logic               cmdTready,
    input  logic               cmdTlast,
    input  renderPkg::cmdWordT cmdTdata,
    output logic               triTvalid,
    input  logic               triTready,
    output logic               triTlast,
    output renderPkg::cmdWordT triTdata,
    output logic               texTvalid,
    input  logic               texTready,
    output logic               texTlast,
    output renderPkg::texelT   texTdata,
    input  logic               rasterizerRunning,
    input  logic               pixelInPipeline,
    output logic               startRendering,
    output renderPkg::cmdWordT confFeatureEnable,
    output renderPkg::cmdWordT confScissorStartXY,
    output renderPkg::cmdWordT confScissorEndXY,
    output renderPkg::cmdWordT confColorClear,
    output logic [15:0]        confDepthClear,
    output logic               colorBufferApply,
    output logic               depthBufferApply,
    output logic               bufferCommit,
    output logic               bufferMemset,
    input  logic               colorBufferApplied,
    input  logic               depthBufferApplied
);
    import renderPkg::*;

    logic        configWrite;
    configIndexT configIndex;
    cmdWordT     configData;
    logic        applyStart;
    fbRequestT   fbRequest;
    logic        fbBusy;

    streamIf #(.payloadT(cmdWordT)) cmdIn ();
    streamIf #(.payloadT(cmdWordT)) cmdOut ();
    streamIf #(.payloadT(texelT)) texIn ();
    streamIf #(.payloadT(texelT)) texOut ();

    assign cmdIn.valid = cmdTvalid;
    assign cmdIn.last = cmdTlast;
    assign cmdIn.data = cmdTdata;
    assign cmdTready = cmdIn.ready;

    assign texTvalid = texOut.valid;
    assign texTlast = texOut.last;
    assign texTdata = texOut.data;
    assign texOut.ready = texTready;

    streamFifo #(.payloadT(cmdWordT), .depth(`CMD_FIFO_DEPTH)) cmdFifo0 (
        .aclk, .resetn, .inStream(cmdIn.sink), .outStream(cmdOut.source)
    );

    streamFifo #(.payloadT(texelT), .depth(`TEX_FIFO_DEPTH)) texFifo0 (
        .aclk, .resetn, .inStream(texIn.sink), .outStream(texOut.source)
    );

    commandParser commandParser0 (
        .aclk, .resetn, .cmdStream(cmdOut.sink), .texStream(texIn.source),
        .triTvalid, .triTready, .triTlast, .triTdata,
        .rasterizerRunning, .pixelInPipeline, .startRendering,
        .configWrite, .configIndex, .configData, .applyStart, .fbRequest, .fbBusy
    );

    configRegisterFile configRegisterFile0 (
        .aclk, .resetn, .configWrite, .configIndex, .configData,
        .confFeatureEnable, .confScissorStartXY, .confScissorEndXY,
        .confColorClear, .confDepthClear
    );

    framebufferControl framebufferControl0 (
        .aclk, .resetn, .applyStart, .fbRequest, .fbBusy,
        .colorBufferApply, .depthBufferApply, .bufferCommit, .bufferMemset,
        .colorBufferApplied, .depthBufferApplied
    );

endmodule

//--- design/commandParser.sv
/* Command decoder that routes payload words to the triangle port, the
   texture stream, the config registers or the framebuffer controller. */
`timescale 1ns/1ps
`include "render_params.svh"

module commandParser
(
    input  logic                   aclk,
    input  logic                   resetn,
    streamIf.sink                  cmdStream,
    streamIf.source                texStream,
    output logic                   triTvalid,
    input  logic                   triTready,
    output logic                   triTlast,
    output renderPkg::cmdWordT     triTdata,
    input  logic                   rasterizerRunning,
    input  logic                   pixelInPipeline,
    output logic                   startRendering,
    output logic                   configWrite,
    output renderPkg::configIndexT configIndex,
    output renderPkg::cmdWordT     configData,
    output logic                   applyStart,
    output renderPkg::fbRequestT   fbRequest,
    input  logic                   fbBusy
);
    import renderPkg::*;

    localparam int triCountWidth = 16;
    localparam int texSizeWidth = 5;

    typedef enum logic [2:0] {stWaitIdle, stCommandIn, stTriangle, stTexture, stConfig} parserStateT;

    parserStateT state;
    logic [31:0] wordCount;
    logic        cmdTake;
    logic        lastWord;
    logic        triDone;
    logic        frontEndIdle;
    opcodeT      opcode;

    assign cmdTake = cmdStream.valid && cmdStream.ready;
    assign lastWord = (wordCount == 32'd1);
    assign triDone = triTvalid && triTready && triTlast;
    assign opcode = opcodeT'(cmdStream.data[`OP_POS +: `OP_SIZE]);

    // No new command while rendering or a buffer operation is in flight
    assign frontEndIdle = !rasterizerRunning && !pixelInPipeline && !fbBusy && !startRendering
        && !applyStart && !(triTvalid && triTlast);

    always_comb
    begin
        case (state)
            stCommandIn: cmdStream.ready = 1'b1;
            stTriangle:  cmdStream.ready = !triTvalid || triTready;
            stTexture:   cmdStream.ready = !texStream.valid || texStream.ready;
            stConfig:    cmdStream.ready = 1'b1;
            default:     cmdStream.ready = 1'b0;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= stWaitIdle;
            triTvalid <= 1'b0;
            triTlast <= 1'b0;
            texStream.valid <= 1'b0;
            texStream.last <= 1'b0;
            configWrite <= 1'b0;
            applyStart <= 1'b0;
        end
        else
        begin
            configWrite <= 1'b0;
            applyStart <= 1'b0;
            if (triTvalid && triTready)
            begin
                triTvalid <= 1'b0;
                triTlast <= 1'b0;
            end
            if (texStream.valid && texStream.ready)
            begin
                texStream.valid <= 1'b0;
                texStream.last <= 1'b0;
            end

            case (state)
                stWaitIdle:
                begin
                    if (frontEndIdle)
                        state <= stCommandIn;
                end
                stCommandIn:
                begin
                    if (cmdTake)
                    begin
                        case (opcode)
                            opTriangleStream:
                            begin
                                wordCount <= 32'(cmdStream.data[triCountWidth-1:0]);
                                state <= (cmdStream.data[triCountWidth-1:0] != '0) ?
                                    stTriangle : stWaitIdle;
                            end
                            opTextureStream:
                            begin
                                wordCount <= 32'd1 << cmdStream.data[texSizeWidth-1:0];
                                state <= (cmdStream.data[texSizeWidth-1:0] != '0) ?
                                    stTexture : stWaitIdle;
                            end
                            opRenderConfig:
                            begin
                                configIndex <= configIndexT'(cmdStream.data[2:0]);
                                state <= stConfig;
                            end
                            opFramebuffer:
                            begin
                                fbRequest.commit <= cmdStream.data[0];
                                fbRequest.memset <= cmdStream.data[1];
                                fbRequest.colorSelect <= cmdStream.data[2];
                                fbRequest.depthSelect <= cmdStream.data[3];
                                applyStart <= 1'b1;
                                state <= stWaitIdle;
                            end
                            default:
                                state <= stWaitIdle;
                        endcase
                    end
                end
                stTriangle:
                begin
                    if (cmdTake)
                    begin
                        triTvalid <= 1'b1;
                        triTdata <= cmdStream.data;
                        triTlast <= lastWord;
                        wordCount <= wordCount - 32'd1;
                        if (lastWord)
                            state <= stWaitIdle;
                    end
                end
                stTexture:
                begin
                    if (cmdTake)
                    begin
                        texStream.valid <= 1'b1;
                        texStream.data <= texelT'(cmdStream.data[$bits(texelT)-1:0]);
                        texStream.last <= lastWord;
                        wordCount <= wordCount - 32'd1;
                        if (lastWord)
                            state <= stWaitIdle;
                    end
                end
                stConfig:
                begin
                    if (cmdTake)
                    begin
                        configWrite <= 1'b1;
                        configData <= cmdStream.data;
                        state <= stWaitIdle;
                    end
                end
                default:
                    state <= stWaitIdle;
            endcase
        end
    end

    // Held from the final triangle word until the rasterizer starts
    always_ff @(posedge aclk)
    begin
        if (!resetn)
            startRendering <= 1'b0;
        else if (triDone)
            startRendering <= 1'b1;
        else if (rasterizerRunning)
            startRendering <= 1'b0;
    end

endmodule

//--- design/framebufferControl.sv
/* Colour and depth buffer apply handshake. Raises the selected apply lines
   and stays busy until the combined acknowledge falls and rises again. */
`timescale 1ns/1ps

module framebufferControl
(
    input  logic                 aclk,
    input  logic                 resetn,
    input  logic                 applyStart,
    input  renderPkg::fbRequestT fbRequest,
    output logic                 fbBusy,
    output logic                 colorBufferApply,
    output logic                 depthBufferApply,
    output logic                 bufferCommit,
    output logic                 bufferMemset,
    input  logic                 colorBufferApplied,
    input  logic                 depthBufferApplied
);
    typedef enum logic {fbWaitCommand, fbWaitDone} fbStateT;

    fbStateT state;
    logic    applied;

    assign applied = colorBufferApplied && depthBufferApplied;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= fbWaitCommand;
            fbBusy <= 1'b0;
            colorBufferApply <= 1'b0;
            depthBufferApply <= 1'b0;
            bufferCommit <= 1'b0;
            bufferMemset <= 1'b0;
        end
        else
        begin
            case (state)
                fbWaitCommand:
                begin
                    if (applyStart)
                    begin
                        bufferCommit <= fbRequest.commit;
                        bufferMemset <= fbRequest.memset;
                        colorBufferApply <= fbRequest.colorSelect;
                        depthBufferApply <= fbRequest.depthSelect;
                        // Nothing to wait for without a selected buffer
                        fbBusy <= fbRequest.colorSelect || fbRequest.depthSelect;
                    end
                    else if (fbBusy && !applied)
                        state <= fbWaitDone;
                end
                fbWaitDone:
                begin
                    if (applied)
                    begin
                        colorBufferApply <= 1'b0;
                        depthBufferApply <= 1'b0;
                        fbBusy <= 1'b0;
                        state <= fbWaitCommand;
                    end
                end
                default:
                    state <= fbWaitCommand;
            endcase
        end
    end

endmodule

//--- design/configRegisterFile.sv
/* Render configuration registers, written by index from the parser and
   presented continuously to the rasterizer and buffers. */
`timescale 1ns/1ps
`include "render_params.svh"

module configRegisterFile
(
    input  logic                   aclk,
    input  logic                   resetn,
    input  logic                   configWrite,
    input  renderPkg::configIndexT configIndex,
    input  renderPkg::cmdWordT     configData,
    output renderPkg::cmdWordT     confFeatureEnable,
    output renderPkg::cmdWordT     confScissorStartXY,
    output renderPkg::cmdWordT     confScissorEndXY,
    output renderPkg::cmdWordT     confColorClear,
    output logic [15:0]            confDepthClear
);
    import renderPkg::*;

    localparam int featureEnableIdx = 0;
    localparam int scissorStartIdx = 1;
    localparam int scissorEndIdx = 2;
    localparam int colorClearIdx = 3;
    localparam int depthClearIdx = 4;

    cmdWordT regs [`RENDER_CONFIG_REGS];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < `RENDER_CONFIG_REGS; i++)
                regs[i] <= '0;
        end
        else if (configWrite)
            regs[configIndex] <= configData;
    end

    assign confFeatureEnable = regs[featureEnableIdx];
    assign confScissorStartXY = regs[scissorStartIdx];
    assign confScissorEndXY = regs[scissorEndIdx];
    assign confColorClear = regs[colorClearIdx];
    assign confDepthClear = regs[depthClearIdx][15:0];

endmodule

//--- design/streamFifo.sv
/* Synchronous circular FIFO for any payload type, storing the last flag
   with each entry. An entry written on one edge can leave on the next. */
`timescale 1ns/1ps

module streamFifo #(
    parameter type payloadT = logic [31:0],
    parameter int  depth    = 4
) (
    input  logic    aclk,
    input  logic    resetn,
    streamIf.sink   inStream,
    streamIf.source outStream
);
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    typedef logic [ptrW-1:0] ptrT;

    payloadT         storage [depth];
    logic            lastStore [depth];
    ptrT             wrPtr;
    ptrT             rdPtr;
    logic [cntW-1:0] count;
    logic [cntW-1:0] nextCount;
    logic            push;
    logic            pop;

    function automatic ptrT advance(ptrT p);
        return (p == ptrT'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = inStream.valid && inStream.ready;
    assign pop = outStream.valid && outStream.ready;

    assign outStream.valid = (count != '0);
    assign outStream.data = storage[rdPtr];
    assign outStream.last = lastStore[rdPtr];

    always_comb
    begin
        nextCount = count;
        if (push && !pop)
            nextCount = count + 1'b1;
        else if (pop && !push)
            nextCount = count - 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            inStream.ready <= 1'b0;
        end
        else
        begin
            if (push)
                wrPtr <= advance(wrPtr);
            if (pop)
                rdPtr <= advance(rdPtr);
            count <= nextCount;
            // Registered full flag
            inStream.ready <= (nextCount != cntW'(depth));
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            storage[wrPtr] <= inStream.data;
            lastStore[wrPtr] <= inStream.last;
        end
    end

endmodule

//--- design/streamIf.sv
/* Ready/valid stream with a last flag and a typed payload.
   The source holds data and last until valid and ready meet. */
`timescale 1ns/1ps

interface streamIf #(
    parameter type payloadT = logic [31:0]
) ();

    logic    valid;
    logic    ready;
    logic    last;
    payloadT data;

    modport source (output valid, output last, output data, input ready);
    modport sink (input valid, input last, input data, output ready);

endinterface

//--- design/renderPkg.sv
/* Types shared by the render front end: stream payloads, opcodes and the
   framebuffer request passed from the parser to the buffer controller. */
package renderPkg;

    typedef logic [31:0] cmdWordT;

    // Low half of a texture stream word
    typedef logic [15:0] texelT;

    typedef logic [2:0] configIndexT;

    // Values outside this list decode as a NOP
    typedef enum logic [3:0]
    {
        opNop            = 4'd0,
        opTriangleStream = 4'd1,
        opTextureStream  = 4'd2,
        opRenderConfig   = 4'd3,
        opFramebuffer    = 4'd4
    } opcodeT;

    typedef struct packed
    {
        logic commit;
        logic memset;
        logic colorSelect;
        logic depthSelect;
    } fbRequestT;

endpackage

//--- design/render_params.svh
/* Field positions, register count and FIFO depths of the render front end.
   Included by every file that decodes commands or sizes a buffer. */
`ifndef RENDER_PARAMS_SVH
`define RENDER_PARAMS_SVH

// Opcode field in bits 31 down to 28 of a command word
`define OP_POS 28
`define OP_SIZE 4

// Indices 0 to 4 are named, 5 to 7 spare
`define RENDER_CONFIG_REGS 8

// Buffer depths in words
`define CMD_FIFO_DEPTH 8
`define TEX_FIFO_DEPTH 4

`endif
